// File: memsys.f
verilog/cache_pkg.sv
verilog/mem_pkg.sv
verilog/cache_array.sv
verilog/banked_mem.sv
verilog/cache_ctrl.sv
verilog/mem_system.sv
sim/mem_system_tb.sv

// File: Bender.yml
package:
  name: memsys

sources:
  - files:
      - verilog/cache_pkg.sv
      - verilog/mem_pkg.sv
      - verilog/cache_array.sv
      - verilog/banked_mem.sv
      - verilog/cache_ctrl.sv
      - verilog/mem_system.sv
  - target: test
    files:
      - sim/mem_system_tb.sv

// File: sim/mem_system_tb.sv
`timescale 1ns/1ns

module mem_system_tb;

   import cache_pkg::*;

   logic        clk;
   logic        arst_n;
   logic        rd;
   logic        wr;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic [15:0] data_out;
   logic        done;
   logic        cache_hit;
   logic        err;

   // Memory as the requester sees it, one entry per 16-bit word
   bit [DATA_W-1:0] shadow_mem [2**(ADDR_W-1)];
   // Expected cache contents
   bit [TAG_W-1:0]  sh_tag     [2**INDEX_W];
   bit              sh_valid   [2**INDEX_W];

   int          fails;
   int          fails_at_start;
   int          tests_passed;
   int          tests_failed;
   string       test_name;
   logic [31:0] seed;
   logic [15:0] rand_addr;

   mem_system mem_system_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .rd        (rd),
      .wr        (wr),
      .addr      (addr),
      .data_in   (data_in),
      .data_out  (data_out),
      .done      (done),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Hit if the line holds this tag
   function automatic bit expect_hit(input logic [15:0] a);
      cache_addr_t ca;
      ca = a;
      return sh_valid[ca.index] && (sh_tag[ca.index] == ca.tag);
   endfunction

   task automatic check_value(input string what, input logic [15:0] exp,
                              input logic [15:0] act);
      assert (act === exp) else begin
         $display("Mismatch in %s: %s expected %h, actual %h", test_name, what, exp, act);
         fails++;
      end
   endtask

   // Step negedge by negedge until done, bounded
   task automatic wait_done(output int cycles);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         // Aligned request must never flag
         assert (addr[0] || !err) else begin
            $display("Error in %s: err raised on aligned address %h", test_name, addr);
            fails++;
         end
      end while (!done && cycles < 40);
      if (!done) begin
         $display("Timeout in %s: no done within 40 cycles for address %h", test_name, addr);
         fails++;
      end
   endtask

   // Outputs seen in the done cycle, before the shadow moves on
   task automatic check_done(input bit is_wr, input logic [15:0] a);
      check_value("cache_hit", {15'd0, expect_hit(a)}, {15'd0, cache_hit});
      check_value("err", {15'd0, a[0]}, {15'd0, err});
      if (!is_wr) begin
         check_value("data_out", shadow_mem[a[15:1]], data_out);
      end
   endtask

   task automatic note_access(input bit is_wr, input logic [15:0] a, input logic [15:0] d);
      cache_addr_t ca;
      ca = a;
      sh_valid[ca.index] = 1'b1;
      sh_tag[ca.index]   = ca.tag;
      if (is_wr) begin
         shadow_mem[a[15:1]] = d;
      end
   endtask

   task automatic do_req(input bit is_wr, input logic [15:0] a, input logic [15:0] d);
      int cycles;
      @(negedge clk);
      rd      = ~is_wr;
      wr      = is_wr;
      addr    = a;
      data_in = d;
      wait_done(cycles);
      if (done) begin
         check_done(is_wr, a);
         // Hit write stores on the edge after done, so keep wr over one replayed compare
         if (is_wr && cache_hit) begin
            wait_done(cycles);
         end
      end
      rd = 1'b0;
      wr = 1'b0;
      note_access(is_wr, a, d);
   endtask

   // rd stays high, next address goes out in each done cycle
   task automatic read_line_burst(input logic [15:0] base);
      logic [15:0] a;
      int          cycles;
      @(negedge clk);
      rd = 1'b1;
      for (int i = 0; i < LINE_WORDS; i++) begin
         // Word order 0, 3, 2, 1
         a    = base + 16'(2 * ((i * 3) % LINE_WORDS));
         addr = a;
         wait_done(cycles);
         if (done) begin
            check_done(1'b0, a);
            check_value("done spacing", 16'd2, 16'(cycles));
         end
         note_access(1'b0, a, 16'h0000);
      end
      rd = 1'b0;
   endtask

   task automatic start_test(input string name);
      test_name      = name;
      fails_at_start = fails;
   endtask

   task automatic end_test();
      if (fails == fails_at_start) begin
         tests_passed++;
         $display("%-14s ok", test_name);
      end else begin
         tests_failed++;
         $display("%-14s FAILED with %0d errors", test_name, fails - fails_at_start);
      end
   endtask

   initial begin
      arst_n       = 1'b0;
      rd           = 1'b0;
      wr           = 1'b0;
      addr         = '0;
      data_in      = '0;
      fails        = 0;
      tests_passed = 0;
      tests_failed = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // Tag 1, index 5
      start_test("cold_read");
      do_req(1'b0, 16'h0828, 16'h0000);
      do_req(1'b0, 16'h0828, 16'h0000);
      do_req(1'b0, 16'h082c, 16'h0000);
      end_test();

      start_test("write_hit");
      do_req(1'b1, 16'h082a, 16'hbeef);
      do_req(1'b0, 16'h082a, 16'h0000);
      end_test();

      // Tags 2 and 6 share index 0x30
      start_test("dirty_evict");
      do_req(1'b1, 16'h1182, 16'h1234);
      do_req(1'b0, 16'h3180, 16'h0000);
      do_req(1'b0, 16'h1182, 16'h0000);
      do_req(1'b0, 16'h1180, 16'h0000);
      end_test();

      // Warm a line with distinct words, then stream reads
      start_test("back_to_back");
      for (int i = 0; i < LINE_WORDS; i++) begin
         do_req(1'b1, 16'h2220 + 16'(2 * i), 16'h5a00 + 16'(i));
      end
      read_line_burst(16'h2220);
      end_test();

      // Odd miss, odd hit, then aligned
      start_test("align_err");
      do_req(1'b0, 16'h4a13, 16'h0000);
      do_req(1'b0, 16'h4a15, 16'h0000);
      do_req(1'b0, 16'h4a14, 16'h0000);
      end_test();

      // Four tags over four indexes keeps conflicts frequent
      start_test("random_mix");
      seed = 32'h9456b26f;
      repeat (200) begin
         seed      = xorshift32(seed);
         rand_addr = {3'b010, seed[1:0], 6'b000110, seed[3:2], seed[5:4], 1'b0};
         do_req(seed[8], rand_addr, seed[31:16]);
      end
      end_test();

      $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed, fails);
      if (fails == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: verilog/mem_system.sv
`timescale 1ns/1ns
`default_nettype none

module mem_system (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        rd,
   input  logic        wr,
   input  logic [15:0] addr,
   input  logic [15:0] data_in,
   output logic [15:0] data_out,
   output logic        done,
   output logic        cache_hit,
   output logic        err
);

   import cache_pkg::*;
   import mem_pkg::*;

   // Controller to array
   cache_cmd_t        cmd;
   logic              c_hit;
   logic              c_valid;
   logic              c_dirty;
   logic [TAG_W-1:0]  c_tag;
   logic [DATA_W-1:0] c_data;

   // Controller to memory
   mem_req_t          mem_req;
   logic [15:0]       mem_rdata;

   // Read word goes out as is
   assign data_out = c_data;

   cache_ctrl cache_ctrl_inst (
      .clk        (clk),
      .arst_n     (arst_n),
      .rd         (rd),
      .wr         (wr),
      .addr       (addr),
      .data_in    (data_in),
      .hit        (c_hit),
      .valid      (c_valid),
      .dirty      (c_dirty),
      .tag_out    (c_tag),
      .cache_data (c_data),
      .mem_rdata  (mem_rdata),
      .cmd        (cmd),
      .mem_req    (mem_req),
      .done       (done),
      .cache_hit  (cache_hit)
   );

   cache_array cache_array_inst (
      .clk      (clk),
      .arst_n   (arst_n),
      .cmd      (cmd),
      .hit      (c_hit),
      .valid    (c_valid),
      .dirty    (c_dirty),
      .tag_out  (c_tag),
      .data_out (c_data),
      .err      (err)
   );

   banked_mem banked_mem_inst (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (mem_req),
      .rdata  (mem_rdata)
   );

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         rd,
   input  logic                         wr,
   input  logic [cache_pkg::ADDR_W-1:0] addr,
   input  logic [cache_pkg::DATA_W-1:0] data_in,
   input  logic                         hit,
   input  logic                         valid,
   input  logic                         dirty,
   input  logic [cache_pkg::TAG_W-1:0]  tag_out,
   input  logic [cache_pkg::DATA_W-1:0] cache_data,
   input  logic [15:0]                  mem_rdata,
   output cache_pkg::cache_cmd_t        cmd,
   output mem_pkg::mem_req_t            mem_req,
   output logic                         done,
   output logic                         cache_hit
);

   import cache_pkg::*;

   ctrl_state_e state_q;
   ctrl_state_e state_d;
   cache_addr_t req_a;

   // Request address split into fields
   assign req_a = addr;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      // Array sees the request unless a state says otherwise
      cmd.enable = 1'b0;
      cmd.comp   = 1'b0;
      cmd.write  = 1'b0;
      cmd.tag    = req_a.tag;
      cmd.index  = req_a.index;
      cmd.offset = req_a.offset;
      cmd.wdata  = data_in;
      // Memory idle, line base of the request
      mem_req.rd    = 1'b0;
      mem_req.wr    = 1'b0;
      mem_req.addr  = {req_a.tag, req_a.index, 3'b000};
      // Writeback data straight from the array
      mem_req.wdata = cache_data;
      done      = 1'b0;
      cache_hit = 1'b0;
      state_d   = state_q;

      case (state_q)
         ST_IDLE: begin
            if (rd | wr) begin
               state_d = ST_COMP;
            end
         end
         // Tag lookup
         ST_COMP: begin
            cmd.enable = 1'b1;
            cmd.comp   = 1'b1;
            state_d    = hit ? ST_HIT : ST_MISS;
         end
         // Hit finishes here, writes land at the edge
         ST_HIT: begin
            cmd.enable = 1'b1;
            cmd.comp   = 1'b1;
            cmd.write  = wr;
            done       = 1'b1;
            cache_hit  = 1'b1;
            state_d    = (rd | wr) ? ST_COMP : ST_IDLE;
         end
         // Direct read of the victim state bits
         ST_MISS: begin
            cmd.enable = 1'b1;
            state_d    = (valid & dirty) ? ST_WB0 : ST_FILL0;
         end
         // Victim words out, one per cycle, bank 0 first
         ST_WB0: begin
            cmd.enable   = 1'b1;
            cmd.offset   = 3'b000;
            mem_req.wr   = 1'b1;
            mem_req.addr = {tag_out, req_a.index, 3'b000};
            state_d      = ST_WB1;
         end
         ST_WB1: begin
            cmd.enable   = 1'b1;
            cmd.offset   = 3'b010;
            mem_req.wr   = 1'b1;
            mem_req.addr = {tag_out, req_a.index, 3'b010};
            state_d      = ST_WB2;
         end
         ST_WB2: begin
            cmd.enable   = 1'b1;
            cmd.offset   = 3'b100;
            mem_req.wr   = 1'b1;
            mem_req.addr = {tag_out, req_a.index, 3'b100};
            state_d      = ST_WB3;
         end
         ST_WB3: begin
            cmd.enable   = 1'b1;
            cmd.offset   = 3'b110;
            mem_req.wr   = 1'b1;
            mem_req.addr = {tag_out, req_a.index, 3'b110};
            state_d      = ST_FILL0;
         end
         // Fill reads issue back to back
         ST_FILL0: begin
            mem_req.rd = 1'b1;
            state_d    = ST_FILL1;
         end
         ST_FILL1: begin
            mem_req.rd   = 1'b1;
            mem_req.addr = {req_a.tag, req_a.index, 3'b010};
            state_d      = ST_FILL2;
         end
         // Word 0 arrives while word 2 is requested
         ST_FILL2: begin
            mem_req.rd   = 1'b1;
            mem_req.addr = {req_a.tag, req_a.index, 3'b100};
            cmd.enable   = 1'b1;
            cmd.write    = 1'b1;
            cmd.offset   = 3'b000;
            cmd.wdata    = mem_rdata;
            state_d      = ST_FILL3;
         end
         ST_FILL3: begin
            mem_req.rd   = 1'b1;
            mem_req.addr = {req_a.tag, req_a.index, 3'b110};
            cmd.enable   = 1'b1;
            cmd.write    = 1'b1;
            cmd.offset   = 3'b010;
            cmd.wdata    = mem_rdata;
            state_d      = ST_FILL4;
         end
         ST_FILL4: begin
            cmd.enable = 1'b1;
            cmd.write  = 1'b1;
            cmd.offset = 3'b100;
            cmd.wdata  = mem_rdata;
            state_d    = ST_FILL5;
         end
         // Last word, line valid after this edge
         ST_FILL5: begin
            cmd.enable = 1'b1;
            cmd.write  = 1'b1;
            cmd.offset = 3'b110;
            cmd.wdata  = mem_rdata;
            state_d    = wr ? ST_WR_FIX : ST_DONE;
         end
         // Store the write data into the refilled line
         ST_WR_FIX: begin
            cmd.enable = 1'b1;
            cmd.comp   = 1'b1;
            cmd.write  = 1'b1;
            state_d    = ST_DONE;
         end
         // Reread through compare, data_out valid here
         ST_DONE: begin
            cmd.enable = 1'b1;
            cmd.comp   = 1'b1;
            done       = 1'b1;
            state_d    = (rd | wr) ? ST_COMP : ST_IDLE;
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   // Done only from the two finishing states, and never twice in a row
   a_done_pulse: assert property (
      @(posedge clk) disable iff (!arst_n)
      done |-> (state_q inside {ST_HIT, ST_DONE}) ##1 !done
   );

endmodule

`default_nettype wire

// File: verilog/banked_mem.sv
`timescale 1ns/1ns
`default_nettype none

module banked_mem (
   input  logic              clk,
   input  logic              arst_n,
   input  mem_pkg::mem_req_t req,
   output logic [15:0]       rdata
);

   import mem_pkg::*;

   // One array per bank
   logic [15:0] bank_mem [BANK_COUNT][BANK_DEPTH];

   logic [$clog2(BANK_COUNT)-1:0] bank_sel;
   logic [$clog2(BANK_DEPTH)-1:0] row;

   // Read pipeline, a valid flag for each stage that feeds a later one
   logic [MEM_RD_LATENCY-2:0] vld_q;
   logic [15:0]               data_q [MEM_RD_LATENCY];

   // Consecutive words go to consecutive banks
   assign bank_sel = req.addr[2:1];
   assign row      = req.addr[15:3];

   // Memory starts out all zero
   initial begin
      for (int b = 0; b < BANK_COUNT; b++) begin
         for (int r = 0; r < BANK_DEPTH; r++) begin
            bank_mem[b][r] = '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req.wr) begin
         bank_mem[bank_sel][row] <= req.wdata;
      end
   end

   // Track reads in flight
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_q <= '0;
      end else begin
         vld_q[0] <= req.rd;
         for (int i = 1; i < MEM_RD_LATENCY-1; i++) begin
            vld_q[i] <= vld_q[i-1];
         end
      end
   end

   // First stage reads the bank, later stages only carry the word
   always_ff @(posedge clk) begin
      if (req.rd) begin
         data_q[0] <= bank_mem[bank_sel][row];
      end
      for (int i = 1; i < MEM_RD_LATENCY; i++) begin
         if (vld_q[i-1]) begin
            data_q[i] <= data_q[i-1];
         end
      end
   end

   assign rdata = data_q[MEM_RD_LATENCY-1];

   a_no_rd_wr: assert property (
      @(posedge clk) disable iff (!arst_n) !(req.rd && req.wr)
   );

   a_aligned: assert property (
      @(posedge clk) disable iff (!arst_n) (req.rd || req.wr) |-> !req.addr[0]
   );

endmodule

`default_nettype wire

// File: verilog/cache_array.sv
`timescale 1ns/1ns
`default_nettype none

module cache_array (
   input  logic                        clk,
   input  logic                        arst_n,
   input  cache_pkg::cache_cmd_t       cmd,
   output logic                        hit,
   output logic                        valid,
   output logic                        dirty,
   output logic [cache_pkg::TAG_W-1:0]  tag_out,
   output logic [cache_pkg::DATA_W-1:0] data_out,
   output logic                        err
);

   import cache_pkg::*;

   // Per line state bits
   logic [2**INDEX_W-1:0] valid_q;
   logic [2**INDEX_W-1:0] dirty_q;

   // Tag and data storage
   logic [TAG_W-1:0]  tag_mem  [2**INDEX_W];
   logic [DATA_W-1:0] data_mem [2**INDEX_W][LINE_WORDS];

   logic [$clog2(LINE_WORDS)-1:0] word_sel;
   logic                          tag_match;
   logic                          wr_hit;
   logic                          fill;

   // Byte offset down to word in line
   assign word_sel = cmd.offset[OFFSET_W-1:1];

   // Lookup is combinational on the command
   assign tag_out   = tag_mem[cmd.index];
   assign valid     = valid_q[cmd.index];
   assign dirty     = dirty_q[cmd.index];
   assign data_out  = data_mem[cmd.index][word_sel];
   assign tag_match = (tag_out == cmd.tag);
   assign hit       = cmd.enable & cmd.comp & valid & tag_match;

   // Odd byte address
   assign err = cmd.enable & cmd.offset[0];

   // Write on a compare hit
   assign wr_hit = cmd.enable & cmd.comp & cmd.write & hit;
   // Direct write, line refill
   assign fill   = cmd.enable & ~cmd.comp & cmd.write;

   always_ff @(posedge clk) begin
      if (wr_hit | fill) begin
         data_mem[cmd.index][word_sel] <= cmd.wdata;
      end
      // Refill brings in the new tag
      if (fill) begin
         tag_mem[cmd.index] <= cmd.tag;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else begin
         if (fill) begin
            valid_q[cmd.index] <= 1'b1;
            // Fresh from memory, so clean
            dirty_q[cmd.index] <= 1'b0;
         end else if (wr_hit) begin
            dirty_q[cmd.index] <= 1'b1;
         end
      end
   end

   // Controller only issues compare writes once the line is resident
   a_comp_wr_hits: assert property (
      @(posedge clk) disable iff (!arst_n)
      (cmd.enable && cmd.comp && cmd.write) |-> hit
   );

endmodule

`default_nettype wire

// File: verilog/mem_pkg.sv
package mem_pkg;

   // Word interleaved banks
   localparam int BANK_COUNT = 4;

   // Words per bank, one row per line address
   localparam int BANK_DEPTH = 8192;

   // Cycles from read request to returned word
   localparam int MEM_RD_LATENCY = 2;

   // Request from the cache controller
   typedef struct packed {
      logic        rd;
      logic        wr;
      // Byte address, always word aligned
      logic [15:0] addr;
      logic [15:0] wdata;
   } mem_req_t;

endpackage

// File: verilog/cache_pkg.sv
package cache_pkg;

   // Byte address and word width
   localparam int ADDR_W = 16;
   localparam int DATA_W = 16;

   // Address split, tag on top and byte offset at the bottom
   localparam int TAG_W = 5;
   localparam int INDEX_W = 8;
   localparam int OFFSET_W = 3;

   // 16-bit words in one line
   localparam int LINE_WORDS = 4;

   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
   } cache_addr_t;

   // Command from the controller into the array
   typedef struct packed {
      logic                enable;
      // Tag compare access, else direct line access
      logic                comp;
      logic                write;
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
      logic [DATA_W-1:0]   wdata;
   } cache_cmd_t;

   typedef enum logic [3:0] {
      ST_IDLE, ST_COMP, ST_HIT, ST_MISS,
      ST_WB0, ST_WB1, ST_WB2, ST_WB3,
      ST_FILL0, ST_FILL1, ST_FILL2, ST_FILL3, ST_FILL4, ST_FILL5,
      ST_WR_FIX, ST_DONE
   } ctrl_state_e;

endpackage
